// ==== rf_wrapper.f ====
source/rf_pkg.sv
source/rf_port_if.sv
source/rf_ram.sv
source/rf_mv.sv
source/rf_ldst.sv
source/rf_access_arbiter.sv
source/rf_wrapper.sv
verif/tb_clock_gen.sv
verif/tb_rf_wrapper.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rf_wrapper -f rf_wrapper.f -o sim_tb

# A failing run exits nonzero, the log search below decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
echo "RESULT: PASS"

// ==== verif/tb_rf_wrapper.sv ====
`timescale 1ns/1ns

module tb_rf_wrapper;
    import rf_pkg::*;

    localparam int DATA_W     = DATA_W_DEF;
    localparam int ADDR_W     = ADDR_W_DEF;
    localparam int MEM_ADDR_W = MEM_ADDR_W_DEF;
    localparam int LINE_W     = LINE_W_DEF;
    localparam int RF_WORDS   = 2**ADDR_W;

    // Longest operation is a full-length load plus two cycles
    // Two idle windows follow the dropped starts
    localparam int NUM_OPS = 30;
    localparam int OP_MAX  = 2**LINE_W + 2;
    localparam int QUIET   = OP_MAX;
    localparam int LIMIT   = ((NUM_OPS * OP_MAX + 2 * QUIET + 10) * 11) / 10;

    logic                  clk, rst;
    logic                  mv_start, mv_done;
    logic [ADDR_W-1:0]     mv_src_addr, mv_dst_addr;
    logic                  ldst_start, ldst_store, ldst_done, busy;
    logic [MEM_ADDR_W-1:0] ldst_mem_addr, mem_addr;
    logic [ADDR_W-1:0]     ldst_rf_addr;
    logic [LINE_W-1:0]     ldst_line_num;
    logic                  mem_rd, mem_wr;
    logic [DATA_W-1:0]     mem_wdata, mem_rdata;
    logic [DATA_W-1:0]     stmm_x_data      [0:3];
    logic                  stmm_x_ld        [0:3];
    logic [DATA_W-1:0]     stmm_y_data      [0:3];
    logic [DATA_W-1:0]     layernorm_x_data [0:3];
    logic                  layernorm_x_ld   [0:3];
    logic [DATA_W-1:0]     layernorm_y_data [0:3];

    // Reference model of the register file and the external memory
    logic [DATA_W-1:0]     model_rf  [RF_WORDS];
    bit                    known     [RF_WORDS];
    logic [DATA_W-1:0]     mem_model [256];
    logic [MEM_ADDR_W-1:0] rd_log[$];
    logic [MEM_ADDR_W-1:0] wr_addr_log[$];
    logic [DATA_W-1:0]     wr_data_log[$];
    logic                  rd_pend;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic [31:0]           lfsr;
    int                    cyc;

    tb_clock_gen #(.HALF_PERIOD(5), .RST_CYCLES(3)) i_clock_gen (.clk(clk), .rst(rst));

    rf_wrapper #(
        .DATA_W     (DATA_W),
        .ADDR_W     (ADDR_W),
        .MEM_ADDR_W (MEM_ADDR_W),
        .LINE_W     (LINE_W)
    ) i_dut (
        .clk              (clk),
        .rst              (rst),
        .mv_start         (mv_start),
        .mv_src_addr      (mv_src_addr),
        .mv_dst_addr      (mv_dst_addr),
        .mv_done          (mv_done),
        .ldst_start       (ldst_start),
        .ldst_store       (ldst_store),
        .ldst_mem_addr    (ldst_mem_addr),
        .ldst_rf_addr     (ldst_rf_addr),
        .ldst_line_num    (ldst_line_num),
        .ldst_done        (ldst_done),
        .busy             (busy),
        .mem_addr         (mem_addr),
        .mem_rd           (mem_rd),
        .mem_wr           (mem_wr),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .stmm_x_data      (stmm_x_data),
        .stmm_x_ld        (stmm_x_ld),
        .stmm_y_data      (stmm_y_data),
        .layernorm_x_data (layernorm_x_data),
        .layernorm_x_ld   (layernorm_x_ld),
        .layernorm_y_data (layernorm_y_data)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic bit is_y(input int a);
        return (a >= STMM_Y_BASE && a < STMM_Y_BASE + 4) || (a >= LN_Y_BASE && a < LN_Y_BASE + 4);
    endfunction

    // Y windows read back the live unit results
    function automatic logic [DATA_W-1:0] rf_read(input int a);
        if (a >= STMM_Y_BASE && a < STMM_Y_BASE + 4) begin
            return stmm_y_data[a - STMM_Y_BASE];
        end else if (a >= LN_Y_BASE && a < LN_Y_BASE + 4) begin
            return layernorm_y_data[a - LN_Y_BASE];
        end
        return model_rf[a];
    endfunction

    task automatic model_write(input int a, input logic [DATA_W-1:0] v);
        if (!is_y(a)) begin
            model_rf[a] = v;
            known[a]    = 1'b1;
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [MEM_ADDR_W-1:0] exp,
                              input logic [MEM_ADDR_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // wr_v and wr_a describe the register write that landed one cycle earlier
    task automatic check_windows(input string name, input logic wr_v, input int wr_a);
        int i;
        for (i = 0; i < 4; i++) begin
            check_flag($sformatf("%s stmm_x_ld[%0d]", name, i),
                       wr_v && (wr_a == STMM_X_BASE + i), stmm_x_ld[i]);
            check_flag($sformatf("%s layernorm_x_ld[%0d]", name, i),
                       wr_v && (wr_a == LN_X_BASE + i), layernorm_x_ld[i]);
            if (known[STMM_X_BASE + i]) begin
                check_word($sformatf("%s stmm_x_data[%0d]", name, i),
                           model_rf[STMM_X_BASE + i], stmm_x_data[i]);
            end
            if (known[LN_X_BASE + i]) begin
                check_word($sformatf("%s layernorm_x_data[%0d]", name, i),
                           model_rf[LN_X_BASE + i], layernorm_x_data[i]);
            end
        end
    endtask

    task automatic new_y();
        int i;
        for (i = 0; i < 4; i++) begin
            stmm_y_data[i]      = rand_bits(DATA_W);
            layernorm_y_data[i] = rand_bits(DATA_W);
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after busy drops
    task automatic run_ldst(input string name, input bit store, input int mbase,
                            input int rbase, input int n, input bit intrude);
        int t;
        int k;
        rd_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        ldst_store    = store;
        ldst_mem_addr = MEM_ADDR_W'(mbase);
        ldst_rf_addr  = ADDR_W'(rbase);
        ldst_line_num = LINE_W'(n);
        ldst_start    = 1'b1;
        for (t = 1; t <= n + 2; t++) begin
            @(negedge clk);
            ldst_start = 1'b0;
            mv_start   = intrude && (t == 1);
            // Word k is written in cycle k+1
            k = t - 2;
            if (!store && k >= 0 && k < n) begin
                model_write((rbase + k) % RF_WORDS, mem_model[(mbase + k) % 256]);
            end
            check_flag({name, " ldst_done"}, t == n + 1, ldst_done);
            check_flag({name, " busy"}, t <= n + 1, busy);
            check_flag({name, " mv_done"}, 1'b0, mv_done);
            check_windows(name, !store && k >= 0 && k < n, (rbase + k) % RF_WORDS);
        end
        if (store) begin
            if (wr_addr_log.size() != n || rd_log.size() != 0) begin
                fail_run($sformatf("%s: %0d memory writes and %0d reads for a %0d-word store",
                                   name, wr_addr_log.size(), rd_log.size(), n));
            end
            for (k = 0; k < n; k++) begin
                check_addr({name, " mem_addr"}, MEM_ADDR_W'(mbase + k), wr_addr_log[k]);
                check_word({name, " mem_wdata"}, rf_read((rbase + k) % RF_WORDS),
                           wr_data_log[k]);
            end
        end else begin
            if (rd_log.size() != n || wr_addr_log.size() != 0) begin
                fail_run($sformatf("%s: %0d memory reads and %0d writes for a %0d-word load",
                                   name, rd_log.size(), wr_addr_log.size(), n));
            end
            for (k = 0; k < n; k++) begin
                check_addr({name, " mem_addr"}, MEM_ADDR_W'(mbase + k), rd_log[k]);
            end
        end
    endtask

    // both raises ldst_start with the mover start, intrude raises it one cycle later
    task automatic run_mv(input string name, input int src, input int dst, input bit both,
                          input bit intrude);
        logic [DATA_W-1:0] v;
        int                t;
        v = rf_read(src);
        rd_log.delete();
        mv_src_addr = ADDR_W'(src);
        mv_dst_addr = ADDR_W'(dst);
        mv_start    = 1'b1;
        ldst_start  = both;
        // Any competing start is a load so that a wrong grant reads memory
        ldst_store  = 1'b0;
        for (t = 1; t <= 3; t++) begin
            @(negedge clk);
            mv_start   = 1'b0;
            ldst_start = intrude && (t == 1);
            if (t == 2) begin
                model_write(dst, v);
            end
            check_flag({name, " mv_done"}, t == 2, mv_done);
            check_flag({name, " busy"}, t <= 2, busy);
            check_flag({name, " ldst_done"}, 1'b0, ldst_done);
            check_windows(name, t == 2, dst);
        end
        if (both || intrude) begin
            // A granted load of any length would have finished by now
            for (t = 0; t < QUIET; t++) begin
                @(negedge clk);
                check_flag({name, " ldst_done"}, 1'b0, ldst_done);
                check_flag({name, " busy"}, 1'b0, busy);
            end
            if (rd_log.size() != 0) begin
                fail_run($sformatf("%s: dropped load start still read memory", name));
            end
        end
    endtask

    // External memory with read data one cycle after mem_rd
    always @(posedge clk) begin
        rd_pend = mem_rd;
        rd_addr = mem_addr;
        if (mem_rd) begin
            rd_log.push_back(mem_addr);
        end
        if (mem_wr) begin
            wr_addr_log.push_back(mem_addr);
            wr_data_log.push_back(mem_wdata);
        end
    end

    always @(negedge clk) begin
        if (rd_pend) begin
            mem_rdata = mem_model[rd_addr[7:0]];
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc > LIMIT) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", LIMIT));
        end
    end

    initial begin
        int i;
        int a;
        int n;
        int mb;
        int rb;
        lfsr          = 32'hb1b15d54;
        cyc           = 0;
        mv_start      = 1'b0;
        mv_src_addr   = '0;
        mv_dst_addr   = '0;
        ldst_start    = 1'b0;
        ldst_store    = 1'b0;
        ldst_mem_addr = '0;
        ldst_rf_addr  = '0;
        ldst_line_num = '0;
        mem_rdata     = '0;
        for (i = 0; i < 256; i++) begin
            mem_model[i] = rand_bits(DATA_W);
        end
        for (i = 0; i < RF_WORDS; i++) begin
            known[i] = 1'b0;
        end
        new_y();
        @(negedge rst);
        @(negedge clk);
        check_flag("reset mv_done", 1'b0, mv_done);
        check_flag("reset ldst_done", 1'b0, ldst_done);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset mem_rd", 1'b0, mem_rd);
        check_flag("reset mem_wr", 1'b0, mem_wr);
        check_windows("reset", 1'b0, 0);

        // Fill every storage word so later stores have known contents
        run_ldst("init_load_16", 1'b0, int'(rand_bits(16)), 16, 16, 1'b0);
        run_ldst("init_load_32", 1'b0, int'(rand_bits(16)), 32, 16, 1'b0);
        run_ldst("init_load_48", 1'b0, int'(rand_bits(16)), 48, 16, 1'b0);
        run_ldst("init_stmm_x", 1'b0, int'(rand_bits(16)), STMM_X_BASE, 4, 1'b0);
        run_ldst("init_ln_x", 1'b0, int'(rand_bits(16)), LN_X_BASE, 4, 1'b0);

        for (i = 0; i < 4; i++) begin
            mb = int'(rand_bits(16));
            rb = 16 + int'(rand_bits(5));
            n  = int'(rand_bits(LINE_W)) + 1;
            run_ldst("load", 1'b0, mb, rb, n, 1'b0);
            mb = int'(rand_bits(16));
            rb = int'(rand_bits(ADDR_W));
            n  = int'(rand_bits(LINE_W)) + 1;
            run_ldst("store", 1'b1, mb, rb, n, 1'b0);
        end

        for (i = 0; i < 4; i++) begin
            a  = 16 + int'(rand_bits(ADDR_W)) % 48;
            rb = int'(rand_bits(ADDR_W));
            run_mv("move", rb, a, 1'b0, 1'b0);
            run_ldst("move_check", 1'b1, int'(rand_bits(16)), a, 1, 1'b0);
        end

        // Operand and result windows
        run_mv("move_to_stmm_x", 16 + int'(rand_bits(5)), STMM_X_BASE + int'(rand_bits(2)),
               1'b0, 1'b0);
        run_mv("move_to_ln_x", 16 + int'(rand_bits(5)), LN_X_BASE + int'(rand_bits(2)),
               1'b0, 1'b0);
        new_y();
        a = 40 + int'(rand_bits(3));
        run_mv("move_from_stmm_y", STMM_Y_BASE + int'(rand_bits(2)), a, 1'b0, 1'b0);
        run_ldst("stmm_y_check", 1'b1, int'(rand_bits(16)), a, 1, 1'b0);
        new_y();
        a = 48 + int'(rand_bits(3));
        run_mv("move_from_ln_y", LN_Y_BASE + int'(rand_bits(2)), a, 1'b0, 1'b0);
        run_ldst("ln_y_check", 1'b1, int'(rand_bits(16)), a, 1, 1'b0);

        // Arbitration
        run_mv("dual_start", int'(rand_bits(ADDR_W)), 16 + int'(rand_bits(5)), 1'b1, 1'b0);
        run_mv("ldst_while_mv", int'(rand_bits(ADDR_W)), 16 + int'(rand_bits(5)), 1'b0, 1'b1);
        run_ldst("mv_while_ldst", 1'b0, int'(rand_bits(16)), 16 + int'(rand_bits(5)), 8, 1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== source/rf_wrapper.sv ====
`timescale 1ns/1ns

module rf_wrapper #(
    parameter int DATA_W     = rf_pkg::DATA_W_DEF,
    parameter int ADDR_W     = rf_pkg::ADDR_W_DEF,
    parameter int MEM_ADDR_W = rf_pkg::MEM_ADDR_W_DEF,
    parameter int LINE_W     = rf_pkg::LINE_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst,

    // Mover control
    input  logic                  mv_start,
    input  logic [ADDR_W-1:0]     mv_src_addr,
    input  logic [ADDR_W-1:0]     mv_dst_addr,
    output logic                  mv_done,

    // Load/store control
    input  logic                  ldst_start,
    input  logic                  ldst_store,
    input  logic [MEM_ADDR_W-1:0] ldst_mem_addr,
    input  logic [ADDR_W-1:0]     ldst_rf_addr,
    input  logic [LINE_W-1:0]     ldst_line_num,
    output logic                  ldst_done,
    output logic                  busy,

    // Memory port with read data one cycle after mem_rd
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic [DATA_W-1:0]     mem_wdata,
    input  logic [DATA_W-1:0]     mem_rdata,

    // Execution units
    output logic [DATA_W-1:0]     stmm_x_data      [0:3],
    output logic                  stmm_x_ld        [0:3],
    input  logic [DATA_W-1:0]     stmm_y_data      [0:3],
    output logic [DATA_W-1:0]     layernorm_x_data [0:3],
    output logic                  layernorm_x_ld   [0:3],
    input  logic [DATA_W-1:0]     layernorm_y_data [0:3]
);

    logic mv_go, ldst_go;

    rf_port_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) mv_port ();
    rf_port_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ldst_port ();
    rf_port_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ram_port ();

    rf_access_arbiter i_rf_access_arbiter (
        .clk        (clk),
        .rst        (rst),
        .mv_start   (mv_start),
        .ldst_start (ldst_start),
        .mv_done    (mv_done),
        .ldst_done  (ldst_done),
        .mv_go      (mv_go),
        .ldst_go    (ldst_go),
        .busy       (busy),
        .mv_port    (mv_port.ram),
        .ldst_port  (ldst_port.ram),
        .ram_port   (ram_port.engine)
    );

    rf_mv #(.ADDR_W(ADDR_W)) i_rf_mv (
        .clk      (clk),
        .rst      (rst),
        .go       (mv_go),
        .src_addr (mv_src_addr),
        .dst_addr (mv_dst_addr),
        .done     (mv_done),
        .port     (mv_port.engine)
    );

    rf_ldst #(
        .DATA_W     (DATA_W),
        .ADDR_W     (ADDR_W),
        .MEM_ADDR_W (MEM_ADDR_W),
        .LINE_W     (LINE_W)
    ) i_rf_ldst (
        .clk       (clk),
        .rst       (rst),
        .go        (ldst_go),
        .store     (ldst_store),
        .mem_base  (ldst_mem_addr),
        .rf_base   (ldst_rf_addr),
        .line_num  (ldst_line_num),
        .done      (ldst_done),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .port      (ldst_port.engine)
    );

    rf_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_rf_ram (
        .clk              (clk),
        .rst              (rst),
        .port             (ram_port.ram),
        .stmm_x_data      (stmm_x_data),
        .stmm_x_ld        (stmm_x_ld),
        .stmm_y_data      (stmm_y_data),
        .layernorm_x_data (layernorm_x_data),
        .layernorm_x_ld   (layernorm_x_ld),
        .layernorm_y_data (layernorm_y_data)
    );

endmodule

// ==== source/rf_access_arbiter.sv ====
`timescale 1ns/1ns

module rf_access_arbiter (
    input  logic      clk,
    input  logic      rst,
    input  logic      mv_start,
    input  logic      ldst_start,
    input  logic      mv_done,
    input  logic      ldst_done,
    output logic      mv_go,
    output logic      ldst_go,
    output logic      busy,
    rf_port_if.ram    mv_port,
    rf_port_if.ram    ldst_port,
    rf_port_if.engine ram_port
);
    import rf_pkg::*;

    rf_owner_t owner, sel;
    logic      idle;

    assign idle    = (owner == OWN_IDLE);
    // Mover has priority when both starts land together
    assign mv_go   = idle && mv_start;
    assign ldst_go = idle && ldst_start && !mv_start;
    assign busy    = !idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_IDLE;
        end else begin
            case (owner)
                OWN_IDLE: begin
                    if (mv_go) begin
                        owner <= OWN_MV;
                    end else if (ldst_go) begin
                        owner <= OWN_LDST;
                    end
                end
                OWN_MV:   if (mv_done) owner <= OWN_IDLE;
                OWN_LDST: if (ldst_done) owner <= OWN_IDLE;
                default:  owner <= OWN_IDLE;
            endcase
        end
    end

    // Steer to the engine being granted already in the grant cycle
    always_comb begin
        if (idle) begin
            sel = mv_go ? OWN_MV : (ldst_go ? OWN_LDST : OWN_IDLE);
        end else begin
            sel = owner;
        end
    end

    always_comb begin
        case (sel)
            OWN_MV: begin
                ram_port.addr = mv_port.addr;
                ram_port.d    = mv_port.d;
                ram_port.we   = mv_port.we;
                ram_port.re   = mv_port.re;
            end
            OWN_LDST: begin
                ram_port.addr = ldst_port.addr;
                ram_port.d    = ldst_port.d;
                ram_port.we   = ldst_port.we;
                ram_port.re   = ldst_port.re;
            end
            default: begin
                ram_port.addr = '0;
                ram_port.d    = '0;
                ram_port.we   = 1'b0;
                ram_port.re   = 1'b0;
            end
        endcase
    end

    assign mv_port.q   = ram_port.q;
    assign ldst_port.q = ram_port.q;

endmodule

// ==== source/rf_ldst.sv ====
`timescale 1ns/1ns

module rf_ldst #(
    parameter int DATA_W     = rf_pkg::DATA_W_DEF,
    parameter int ADDR_W     = rf_pkg::ADDR_W_DEF,
    parameter int MEM_ADDR_W = rf_pkg::MEM_ADDR_W_DEF,
    parameter int LINE_W     = rf_pkg::LINE_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  logic                  store,
    input  logic [MEM_ADDR_W-1:0] mem_base,
    input  logic [ADDR_W-1:0]     rf_base,
    input  logic [LINE_W-1:0]     line_num,
    output logic                  done,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic [DATA_W-1:0]     mem_wdata,
    input  logic [DATA_W-1:0]     mem_rdata,
    rf_port_if.engine             port
);

    logic                  st_q;
    logic [MEM_ADDR_W-1:0] mem_base_q;
    logic [ADDR_W-1:0]     rf_base_q;
    logic [LINE_W:0]       n_q;

    // Request stage: memory reads on load, register reads on store
    logic                  req_act;
    logic [LINE_W:0]       req_idx;
    logic                  req_v, req_last, dir;
    logic [LINE_W:0]       cur_idx, cur_n;
    logic [MEM_ADDR_W-1:0] cur_mem_base;
    logic [ADDR_W-1:0]     cur_rf_base;

    // Completion stage trails the request stage by one cycle
    logic                  cmp_v, cmp_last;
    logic [LINE_W:0]       cmp_idx;

    // Go cycle uses the inputs directly, later cycles the latched copy
    assign req_v        = go || req_act;
    assign dir          = go ? store : st_q;
    assign cur_idx      = go ? '0 : req_idx;
    assign cur_n        = go ? {(line_num == '0), line_num} : n_q;
    assign cur_mem_base = go ? mem_base : mem_base_q;
    assign cur_rf_base  = go ? rf_base : rf_base_q;
    assign req_last     = (cur_idx == cur_n - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            req_act  <= 1'b0;
            cmp_v    <= 1'b0;
            cmp_last <= 1'b0;
            done     <= 1'b0;
        end else begin
            req_act  <= req_v && !req_last;
            cmp_v    <= req_v;
            cmp_last <= req_v && req_last;
            done     <= cmp_last;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            st_q       <= store;
            mem_base_q <= mem_base;
            rf_base_q  <= rf_base;
            n_q        <= cur_n;
        end
        req_idx <= cur_idx + 1'b1;
        cmp_idx <= cur_idx;
    end

    // Requests address one side, completions the other
    assign mem_rd    = req_v && !dir;
    assign mem_wr    = cmp_v && dir;
    assign mem_addr  = dir ? mem_base_q + MEM_ADDR_W'(cmp_idx)
                           : cur_mem_base + MEM_ADDR_W'(cur_idx);
    assign mem_wdata = port.q;
    assign port.re   = req_v && dir;
    assign port.we   = cmp_v && !dir;
    assign port.addr = dir ? cur_rf_base + ADDR_W'(cur_idx)
                           : rf_base_q + ADDR_W'(cmp_idx);
    assign port.d    = mem_rdata;

endmodule

// ==== source/rf_mv.sv ====
`timescale 1ns/1ns

module rf_mv #(
    parameter int ADDR_W = rf_pkg::ADDR_W_DEF
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              go,
    input  logic [ADDR_W-1:0] src_addr,
    input  logic [ADDR_W-1:0] dst_addr,
    output logic              done,
    rf_port_if.engine         port
);

    // High in the cycle after go, while the copy is written back
    logic              wr_pend;
    logic [ADDR_W-1:0] dst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend <= 1'b0;
            done    <= 1'b0;
        end else begin
            wr_pend <= go;
            done    <= wr_pend;
        end
    end

    // Destination held for the write cycle
    always_ff @(posedge clk) begin
        if (go) begin
            dst_q <= dst_addr;
        end
    end

    // Source read goes out in the go cycle itself
    always_comb begin
        port.re = go;
        port.we = wr_pend;
        if (wr_pend) begin
            port.addr = dst_q;
        end else begin
            port.addr = src_addr;
        end
        // read data comes back just in time for the write
        port.d = port.q;
    end

endmodule

// ==== source/rf_ram.sv ====
`timescale 1ns/1ns

module rf_ram #(
    parameter int DATA_W = rf_pkg::DATA_W_DEF,
    parameter int ADDR_W = rf_pkg::ADDR_W_DEF
) (
    input  logic              clk,
    input  logic              rst,
    rf_port_if.ram            port,
    output logic [DATA_W-1:0] stmm_x_data      [0:3],
    output logic              stmm_x_ld        [0:3],
    input  logic [DATA_W-1:0] stmm_y_data      [0:3],
    output logic [DATA_W-1:0] layernorm_x_data [0:3],
    output logic              layernorm_x_ld   [0:3],
    input  logic [DATA_W-1:0] layernorm_y_data [0:3]
);
    import rf_pkg::*;

    // Window number is the address without its two slot bits
    localparam logic [ADDR_W-3:0] SX_WIN = (ADDR_W-2)'(STMM_X_BASE / 4);
    localparam logic [ADDR_W-3:0] SY_WIN = (ADDR_W-2)'(STMM_Y_BASE / 4);
    localparam logic [ADDR_W-3:0] LX_WIN = (ADDR_W-2)'(LN_X_BASE / 4);
    localparam logic [ADDR_W-3:0] LY_WIN = (ADDR_W-2)'(LN_Y_BASE / 4);

    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic [ADDR_W-3:0] win;
    logic [1:0]        slot;
    logic              in_sx, in_sy, in_lx, in_ly;

    assign win   = port.addr[ADDR_W-1:2];
    assign slot  = port.addr[1:0];
    assign in_sx = (win == SX_WIN);
    assign in_sy = (win == SY_WIN);
    assign in_lx = (win == LX_WIN);
    assign in_ly = (win == LY_WIN);

    // Writes into a Y window are dropped since it has no storage
    always_ff @(posedge clk) begin
        if (port.we && !in_sy && !in_ly) begin
            mem[port.addr] <= port.d;
        end
        if (port.re) begin
            if (in_sy) begin
                port.q <= stmm_y_data[slot];
            end else if (in_ly) begin
                port.q <= layernorm_y_data[slot];
            end else begin
                port.q <= mem[port.addr];
            end
        end
    end

    // Operand windows mirrored straight out of storage
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            stmm_x_data[i]      = mem[STMM_X_BASE + i];
            layernorm_x_data[i] = mem[LN_X_BASE + i];
        end
    end

    // Load strobe lines up with the new value appearing on x_data
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                stmm_x_ld[i]      <= 1'b0;
                layernorm_x_ld[i] <= 1'b0;
            end else begin
                stmm_x_ld[i]      <= port.we && in_sx && (slot == 2'(i));
                layernorm_x_ld[i] <= port.we && in_lx && (slot == 2'(i));
            end
        end
    end

endmodule

// ==== source/rf_port_if.sv ====
`timescale 1ns/1ns

interface rf_port_if #(
    parameter int DATA_W = rf_pkg::DATA_W_DEF,
    parameter int ADDR_W = rf_pkg::ADDR_W_DEF
);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] d;
    logic              we;
    logic              re;
    // Registered read data, valid the cycle after re
    logic [DATA_W-1:0] q;

    modport engine (
        output addr, d, we, re,
        input  q
    );

    modport ram (
        input  addr, d, we, re,
        output q
    );
endinterface

// ==== source/rf_pkg.sv ====
package rf_pkg;

    // Default widths for the top-level parameters
    localparam int DATA_W_DEF     = 32;
    localparam int ADDR_W_DEF     = 6;
    localparam int MEM_ADDR_W_DEF = 16;
    localparam int LINE_W_DEF     = 4;

    // Four-word windows shared with the execution units
    // X windows hold operands, Y windows read back unit results
    localparam int STMM_X_BASE = 0;
    localparam int STMM_Y_BASE = 4;
    localparam int LN_X_BASE   = 8;
    localparam int LN_Y_BASE   = 12;

    // Engine currently holding the register-file port
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_MV,
        OWN_LDST
    } rf_owner_t;

endpackage
